// ==== rv_fetch.f ====
src/rv_core_pkg.sv
src/rv_mem_pkg.sv
src/next_pc_unit.sv
src/imem_sram.sv
src/fetch_ctrl.sv
src/fetch_status_regs.sv
src/fetch_top.sv
test/tb_clock.sv
test/fetch_tb.sv

// ==== test/fetch_tb.sv ====
// fetch stage testbench
`timescale 1ns/1ps

module fetch_tb;

  import rv_core_pkg::*;
  import rv_mem_pkg::*;

  localparam int num_fetches      = 200;
  localparam int cycles_per_fetch = 40;
  localparam int cycle_limit      = num_fetches * cycles_per_fetch;
  localparam int ebreak_fetch     = 180;
  localparam int fetch_edges      = 5;
  localparam int halt_watch       = 6;
  localparam logic [imem_index_bits-1:0] ebreak_index = 8'ha5;

  logic                       clk;
  logic                       rst;
  logic                       pc_wen;
  pc_sel_e                    pc_sel;
  logic [xlen-1:0]            jalr_target;
  logic [xlen-1:0]            branch_target;
  logic [xlen-1:0]            jal_target;
  logic                       idu_ready;
  logic                       load_en;
  logic [imem_index_bits-1:0] load_index;
  logic [31:0]                load_data;
  logic [xlen-1:0]            pc;
  logic [31:0]                inst;
  logic                       inst_valid;
  logic                       halted;
  logic [31:0]                fetch_count;
  logic [xlen-1:0]            last_pc;

  // reference model state
  logic [31:0]     image [imem_depth];
  logic [xlen-1:0] model_pc;
  logic [31:0]     model_count;
  logic [xlen-1:0] model_last_pc;
  logic            model_halted;
  logic [31:0]     rand_state;
  int              errors;
  int              cycles;

  tb_clock u_clock (
    .clk (clk)
  );

  fetch_top dut (
    .clk           (clk),
    .rst           (rst),
    .pc_wen        (pc_wen),
    .pc_sel        (pc_sel),
    .jalr_target   (jalr_target),
    .branch_target (branch_target),
    .jal_target    (jal_target),
    .idu_ready     (idu_ready),
    .load_en       (load_en),
    .load_index    (load_index),
    .load_data     (load_data),
    .pc            (pc),
    .inst          (inst),
    .inst_valid    (inst_valid),
    .halted        (halted),
    .fetch_count   (fetch_count),
    .last_pc       (last_pc)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // next pc per source code, with codes 5 to 7 as sequential
  function automatic logic [xlen-1:0] select_next_pc(input logic [2:0] code,
                                                    input logic [xlen-1:0] cur,
                                                    input logic [xlen-1:0] jalr_t,
                                                    input logic [xlen-1:0] br_t,
                                                    input logic [xlen-1:0] jal_t);
    case (code)
      3'd1: return jalr_t;
      3'd2: return br_t;
      3'd3: return jal_t;
      3'd4: return 32'h0000_0100;
      default: return cur + 32'd4;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("CHECK FAILED: %s expected %08h actual %08h", name, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  // stray write-back pulses while busy or halted must be ignored
  task automatic drive_random_inputs();
    logic [31:0] r;
    r = next_rand();
    idu_ready = r[16];
    pc_wen    = r[17];
  endtask

  task automatic check_reset_state();
    if (pc !== 32'h0000_0000) report_mismatch("pc", 32'h0000_0000, pc);
    if (inst_valid !== 1'b0) report_mismatch("inst_valid", 0, inst_valid);
    if (halted !== 1'b0) report_mismatch("halted", 0, halted);
    if (fetch_count !== 32'd0) report_mismatch("fetch_count", 0, fetch_count);
    if (last_pc !== 32'd0) report_mismatch("last_pc", 0, last_pc);
  endtask

  // random words everywhere except one ebreak slot
  task automatic load_image();
    logic [31:0] word;
    for (int i = 0; i < imem_depth; i++) begin
      word = next_rand();
      if (word == ebreak_inst) begin
        word = word ^ 32'h1;
      end
      if (i == ebreak_index) begin
        word = ebreak_inst;
      end
      @(negedge clk);
      load_en    = 1'b1;
      load_index = imem_index_bits'(i);
      load_data  = word;
      image[i]   = word;
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic do_fetch(input logic [2:0] code, input logic [xlen-1:0] jalr_t,
                          input logic [xlen-1:0] br_t, input logic [xlen-1:0] jal_t);
    logic [xlen-1:0] exp_pc;
    logic [31:0]     exp_inst;
    logic [xlen-1:0] held_pc;
    logic [31:0]     held_inst;
    logic [31:0]     r;
    logic            ready;
    int              edges;
    exp_pc = select_next_pc(code, model_pc, jalr_t, br_t, jal_t);
    drive_random_inputs();
    pc_wen        = 1'b1;
    pc_sel        = pc_sel_e'(code);
    jalr_target   = jalr_t;
    branch_target = br_t;
    jal_target    = jal_t;
    @(negedge clk);
    pc_wen = 1'b0;
    if (model_halted) begin
      // halted core ignores the write
      for (int k = 0; k < halt_watch; k++) begin
        if (pc !== model_pc) report_mismatch("pc", model_pc, pc);
        if (fetch_count !== model_count) report_mismatch("fetch_count", model_count, fetch_count);
        if (inst_valid !== 1'b0) report_mismatch("inst_valid", 0, inst_valid);
        if (halted !== 1'b1) report_mismatch("halted", 1, halted);
        drive_random_inputs();
        @(negedge clk);
      end
    end else begin
      model_pc = exp_pc;
      if (pc !== model_pc) report_mismatch("pc", model_pc, pc);
      // count edges after the accepting edge until the word shows up
      edges = 0;
      while (!inst_valid && edges < 4 * fetch_edges) begin
        drive_random_inputs();
        @(negedge clk);
        edges++;
        if (pc !== model_pc) report_mismatch("pc", model_pc, pc);
      end
      if (!inst_valid) begin
        report_problem("inst_valid never rose after an accepted pc write");
      end else begin
        if (edges != fetch_edges) report_mismatch("inst_valid rise edge", fetch_edges, edges);
        exp_inst = image[model_pc[imem_index_bits+1:2]];
        if (inst !== exp_inst) report_mismatch("inst", exp_inst, inst);
        held_pc   = pc;
        held_inst = inst;
        ready     = 1'b0;
        // decode back-pressure until a ready cycle
        while (!ready) begin
          r = next_rand();
          ready = r[16];
          idu_ready = ready;
          pc_wen    = r[17];
          @(negedge clk);
          if (!ready) begin
            if (inst_valid !== 1'b1) report_mismatch("inst_valid", 1, inst_valid);
            if (inst !== held_inst) report_mismatch("inst", held_inst, inst);
            if (pc !== held_pc) report_mismatch("pc", held_pc, pc);
          end
        end
        model_count   = model_count + 32'd1;
        model_last_pc = model_pc;
        if (exp_inst == ebreak_inst) begin
          model_halted = 1'b1;
        end
        if (inst_valid !== 1'b0) report_mismatch("inst_valid", 0, inst_valid);
        if (pc !== held_pc) report_mismatch("pc", held_pc, pc);
        if (fetch_count !== model_count) report_mismatch("fetch_count", model_count, fetch_count);
        if (last_pc !== model_last_pc) report_mismatch("last_pc", model_last_pc, last_pc);
        if (halted !== model_halted) report_mismatch("halted", model_halted, halted);
      end
    end
    pc_wen    = 1'b0;
    idu_ready = 1'b0;
  endtask

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("summary: %0d handoffs, %0d errors", model_count, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] t2;
    rand_state    = 32'h12d0;
    errors        = 0;
    cycles        = 0;
    rst           = 1'b1;
    pc_wen        = 1'b0;
    pc_sel        = pc_seq;
    jalr_target   = '0;
    branch_target = '0;
    jal_target    = '0;
    idu_ready     = 1'b0;
    load_en       = 1'b0;
    load_index    = '0;
    load_data     = '0;
    model_pc      = 32'h0000_0000;
    model_count   = '0;
    model_last_pc = '0;
    model_halted  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();
    load_image();
    for (int n = 0; n < num_fetches; n++) begin
      @(negedge clk);
      if (n == ebreak_fetch) begin
        // jump to the ebreak word through a wrapped address
        t2 = 32'h0004_0000 | (32'(ebreak_index) << 2);
        do_fetch(3'd3, '0, '0, t2);
      end else begin
        r  = next_rand();
        t0 = next_rand() & 32'hffff_fffc;
        t1 = next_rand() & 32'hffff_fffc;
        t2 = next_rand() & 32'hffff_fffc;
        do_fetch(r[30:28], t0, t1, t2);
      end
    end
    if (!model_halted) begin
      report_problem("the ebreak word was never handed off");
    end
    $display("summary: %0d handoffs, %0d errors", model_count, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 100 ns period
  localparam int half_period = 50;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

endmodule

// ==== src/fetch_top.sv ====
// instruction fetch stage top
`timescale 1ns/1ps

module fetch_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  pc_wen,
  input  rv_core_pkg::pc_sel_e                  pc_sel,
  input  logic [rv_core_pkg::xlen-1:0]          jalr_target,
  input  logic [rv_core_pkg::xlen-1:0]          branch_target,
  input  logic [rv_core_pkg::xlen-1:0]          jal_target,
  input  logic                                  idu_ready,
  input  logic                                  load_en,
  input  logic [rv_mem_pkg::imem_index_bits-1:0] load_index,
  input  logic [31:0]                           load_data,
  output logic [rv_core_pkg::xlen-1:0]          pc,
  output logic [31:0]                           inst,
  output logic                                  inst_valid,
  output logic                                  halted,
  output logic [31:0]                           fetch_count,
  output logic [rv_core_pkg::xlen-1:0]          last_pc
);

  import rv_mem_pkg::*;

  logic                       pc_load;
  logic                       rd_req;
  logic                       rd_valid;
  logic [31:0]                rd_data;
  logic [imem_index_bits-1:0] rd_index;
  logic                       handoff;
  logic                       handoff_ebreak;

  // word index, wraps every 1 KiB
  assign rd_index = pc[imem_index_bits+1:2];

  next_pc_unit u_next_pc (
    .clk           (clk),
    .rst           (rst),
    .pc_load       (pc_load),
    .pc_sel        (pc_sel),
    .jalr_target   (jalr_target),
    .branch_target (branch_target),
    .jal_target    (jal_target),
    .pc            (pc)
  );

  imem_sram u_imem (
    .clk        (clk),
    .rst        (rst),
    .rd_req     (rd_req),
    .rd_index   (rd_index),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .load_en    (load_en),
    .load_index (load_index),
    .load_data  (load_data)
  );

  fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .pc_wen         (pc_wen),
    .halted         (halted),
    .pc_load        (pc_load),
    .rd_req         (rd_req),
    .rd_valid       (rd_valid),
    .rd_data        (rd_data),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .idu_ready      (idu_ready),
    .handoff        (handoff),
    .handoff_ebreak (handoff_ebreak)
  );

  fetch_status_regs u_status (
    .clk            (clk),
    .rst            (rst),
    .handoff        (handoff),
    .handoff_ebreak (handoff_ebreak),
    .pc             (pc),
    .halted         (halted),
    .fetch_count    (fetch_count),
    .last_pc        (last_pc)
  );

endmodule

// ==== src/fetch_status_regs.sv ====
// fetch status registers
`timescale 1ns/1ps

module fetch_status_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         handoff,
  input  logic                         handoff_ebreak,
  input  logic [rv_core_pkg::xlen-1:0] pc,
  output logic                         halted,
  output logic [31:0]                  fetch_count,
  output logic [rv_core_pkg::xlen-1:0] last_pc
);

  // sticky halt, cleared only by reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (handoff_ebreak) begin
      halted <= 1'b1;
    end
  end

  // handed-off instruction count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fetch_count <= '0;
    end else if (handoff) begin
      fetch_count <= fetch_count + 32'd1;
    end
  end

  // pc of the most recent handoff
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_pc <= '0;
    end else if (handoff) begin
      last_pc <= pc;
    end
  end

endmodule

// ==== src/fetch_ctrl.sv ====
// fetch controller
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic        clk,
  input  logic        rst,
  input  logic        pc_wen,
  input  logic        halted,
  output logic        pc_load,
  output logic        rd_req,
  input  logic        rd_valid,
  input  logic [31:0] rd_data,
  output logic [31:0] inst,
  output logic        inst_valid,
  input  logic        idu_ready,
  output logic        handoff,
  output logic        handoff_ebreak
);

  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    idle     = 2'b00,
    req      = 2'b01,
    wait_mem = 2'b10,
    done     = 2'b11
  } state_e;

  state_e      state;
  state_e      state_next;
  logic [31:0] inst_buf;

  // write-back pulse only counts in idle, and never after a halt
  assign pc_load = (state == idle) && pc_wen && !halted;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (pc_load) begin
          state_next = req;
        end
      end
      req: begin
        state_next = wait_mem;
      end
      wait_mem: begin
        if (rd_valid) begin
          state_next = done;
        end
      end
      done: begin
        // decode back-pressure holds us here
        if (idu_ready) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= idle;
      rd_req <= 1'b0;
    end else begin
      state <= state_next;
      // single-cycle strobe on leaving req
      rd_req <= (state == req);
    end
  end

  // instruction buffer, loaded when the sram answers
  always_ff @(posedge clk) begin
    if ((state == wait_mem) && rd_valid) begin
      inst_buf <= rd_data;
    end
  end

  assign inst       = inst_buf;
  assign inst_valid = (state == done);

  // handoff is the accepted cycle of the valid/ready pair
  assign handoff        = inst_valid && idu_ready;
  assign handoff_ebreak = handoff && (inst_buf == ebreak_inst);

endmodule

// ==== src/imem_sram.sv ====
// fixed-latency instruction sram
`timescale 1ns/1ps

module imem_sram (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  rd_req,
  input  logic [rv_mem_pkg::imem_index_bits-1:0] rd_index,
  output logic [31:0]                           rd_data,
  output logic                                  rd_valid,
  input  logic                                  load_en,
  input  logic [rv_mem_pkg::imem_index_bits-1:0] load_index,
  input  logic [31:0]                           load_data
);

  import rv_mem_pkg::*;

  logic [31:0]                mem [imem_depth];
  logic [imem_latency-1:0]    valid_q;
  logic [imem_index_bits-1:0] index_q [imem_latency];
  logic [imem_index_bits-1:0] out_index;

  // request strobes shift toward the result stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[imem_latency-2:0], rd_req};
    end
  end

  // index travels alongside its strobe
  always_ff @(posedge clk) begin
    index_q[0] <= rd_index;
    for (int i = 1; i < imem_latency; i++) begin
      index_q[i] <= index_q[i-1];
    end
  end

  // word load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_index] <= load_data;
    end
  end

  assign out_index = index_q[imem_latency-1];
  assign rd_valid  = valid_q[imem_latency-1];

  // array read at the last stage
  // a load to the same word this cycle is forwarded
  always_comb begin
    if (load_en && (load_index == out_index)) begin
      rd_data = load_data;
    end else begin
      rd_data = mem[out_index];
    end
  end

endmodule

// ==== src/next_pc_unit.sv ====
// program counter and next-pc select
`timescale 1ns/1ps

module next_pc_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           pc_load,
  input  rv_core_pkg::pc_sel_e           pc_sel,
  input  logic [rv_core_pkg::xlen-1:0]   jalr_target,
  input  logic [rv_core_pkg::xlen-1:0]   branch_target,
  input  logic [rv_core_pkg::xlen-1:0]   jal_target,
  output logic [rv_core_pkg::xlen-1:0]   pc
);

  import rv_core_pkg::*;

  logic [xlen-1:0] pc_plus;
  logic [xlen-1:0] next_pc;

  assign pc_plus = pc + pc_step;

  // source mux, undefined codes fall back to sequential
  always_comb begin
    case (pc_sel)
      pc_seq: begin
        next_pc = pc_plus;
      end
      pc_jalr: begin
        next_pc = jalr_target;
      end
      pc_branch: begin
        next_pc = branch_target;
      end
      pc_jal: begin
        next_pc = jal_target;
      end
      pc_trap: begin
        next_pc = trap_vector;
      end
      default: begin
        next_pc = pc_plus;
      end
    endcase
  end

  // pc only moves when the controller accepts a write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (pc_load) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== src/rv_mem_pkg.sv ====
// instruction memory definitions
package rv_mem_pkg;

  // word index width, taken from pc[9:2]
  localparam int unsigned imem_index_bits = 8;

  // number of 32-bit words, 1 KiB total
  localparam int unsigned imem_depth = 1 << imem_index_bits;

  // edges from request to result
  localparam int unsigned imem_latency = 3;

endpackage

// ==== src/rv_core_pkg.sv ====
// rv32 core definitions
package rv_core_pkg;

  // data and address width
  localparam int unsigned xlen = 32;

  // pc after reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // sequential increment, one 32-bit word
  localparam logic [xlen-1:0] pc_step = 32'd4;

  // fixed trap entry address
  localparam logic [xlen-1:0] trap_vector = 32'h0000_0100;

  // ebreak: system opcode with imm = 1
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  // next-pc source as driven by decode
  // codes 101 to 111 are undefined and behave as pc_seq
  typedef enum logic [2:0] {
    pc_seq    = 3'b000,
    pc_jalr   = 3'b001,
    pc_branch = 3'b010,
    pc_jal    = 3'b011,
    pc_trap   = 3'b100
  } pc_sel_e;

endpackage
